// File: project.f
+incdir+test
src/muldiv_op_pkg.sv
src/muldiv_route_pkg.sv
src/sync_fifo.sv
src/mult_pipe.sv
src/div_lane.sv
src/issue_dispatch.sv
src/result_collect.sv
src/muldiv_unit.sv
test/muldiv_unit_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the muldiv unit testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f project.f \
    --top-module muldiv_unit_tb \
    -o muldiv_sim

./obj_dir/muldiv_sim | tee sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

if ! grep -q "Result: PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

exit 0

// File: src/div_lane.sv
`timescale 1ns/1ps
`default_nettype none

module div_lane (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    start,
    input  muldiv_op_pkg::md_req_t  req,
    output logic                    idle,
    output logic                    res_valid,
    output muldiv_op_pkg::md_res_t  res,
    input  logic                    res_ready
);

    import muldiv_op_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_busy,
        st_done
    } state_e;

    state_e      state;
    logic [4:0]  step;
    logic [31:0] rem;
    logic [31:0] quo;
    logic [31:0] dvs;
    logic        neg_q;
    logic        neg_r;
    logic        sgn;
    logic        a_neg;
    logic        b_neg;
    logic [32:0] shifted;
    logic [32:0] diff;
    logic        fits;

    assign sgn   = op_is_signed(req.op);
    assign a_neg = sgn & req.a[31];
    assign b_neg = sgn & req.b[31];

    // one restoring step brings in the next dividend bit and tries the subtract.
    assign shifted = {rem, quo[31]};
    assign diff    = shifted - {1'b0, dvs};
    assign fits    = !diff[32];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state <= st_idle;
            step  <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_busy;
                        step  <= '0;
                    end
                end
                st_busy: begin
                    step <= step + 1'b1;
                    if (step == 5'd31) begin
                        state <= st_done;
                    end
                end
                st_done: begin
                    if (res_ready) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    ////////////////////////////////////////
    // setup on the accept edge, then 32 iterations.
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            quo   <= a_neg ? -req.a : req.a;
            dvs   <= b_neg ? -req.b : req.b;
            rem   <= '0;
            // a zero divisor leaves all ones in the quotient, so keep its sign.
            neg_q <= (a_neg ^ b_neg) && (req.b != '0);
            neg_r <= a_neg;
        end else if (state == st_busy) begin
            rem <= fits ? diff[31:0] : shifted[31:0];
            quo <= {quo[30:0], fits};
        end
    end

    // remainder follows the dividend sign.
    always_comb begin
        res.hi = neg_r ? -rem : rem;
        res.lo = neg_q ? -quo : quo;
    end

    assign idle      = (state == st_idle);
    assign res_valid = (state == st_done);

    a_start_when_idle: assert property (@(posedge clk) disable iff (rst) start |-> idle);

    a_fixed_latency: assert property (@(posedge clk) disable iff (rst)
        (start && !flush) ##1 (!flush [*32]) |=> res_valid);

endmodule

`default_nettype wire

// File: src/issue_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module issue_dispatch #(
    parameter int NUM_LANES = 4
) (
    input  logic                          in_valid,
    input  muldiv_op_pkg::md_req_t        in_req,
    output logic                          in_ready,
    output logic                          mul_valid,
    input  logic                          mul_ready,
    output logic [NUM_LANES-1:0]          lane_valid,
    input  logic [NUM_LANES-1:0]          lane_idle,
    output muldiv_op_pkg::md_req_t        unit_req,
    output logic                          order_push,
    output muldiv_route_pkg::order_entry_t order_entry,
    input  logic                          order_full,
    input  logic                          flush
);

    import muldiv_op_pkg::*;
    import muldiv_route_pkg::*;

    logic                 is_div;
    logic                 any_idle;
    logic [NUM_LANES-1:0] lane_pick;
    unit_id_t             lane_id;
    logic                 unit_ok;
    logic                 fire;

    assign is_div = op_is_div(in_req.op);

    // priority encoder, lowest idle lane wins.
    always_comb begin
        any_idle  = 1'b0;
        lane_pick = '0;
        lane_id   = UNIT_MUL;
        for (int k = NUM_LANES - 1; k >= 0; k--) begin
            if (lane_idle[k]) begin
                any_idle     = 1'b1;
                lane_pick    = '0;
                lane_pick[k] = 1'b1;
                lane_id      = unit_id_t'(k + 1);
            end
        end
    end

    // the order queue must take the entry in the same cycle.
    assign unit_ok  = is_div ? any_idle : mul_ready;
    assign in_ready = unit_ok && !order_full && !flush;
    assign fire     = in_valid && in_ready;

    assign mul_valid  = fire && !is_div;
    assign lane_valid = (fire && is_div) ? lane_pick : '0;
    assign unit_req   = in_req;

    assign order_push  = fire;
    assign order_entry = '{unit: (is_div ? lane_id : UNIT_MUL)};

endmodule

`default_nettype wire

// File: src/muldiv_op_pkg.sv
`default_nettype none

package muldiv_op_pkg;

    // operation codes, same order as the core's exe field.
    typedef enum logic [1:0] {
        op_mult  = 2'd0,
        op_multu = 2'd1,
        op_div   = 2'd2,
        op_divu  = 2'd3
    } op_e;

    typedef struct packed {
        op_e         op;
        logic [31:0] a;
        logic [31:0] b;
    } md_req_t;

    // multiply gives upper and lower product halves, divide gives remainder and quotient.
    typedef struct packed {
        logic [31:0] hi;
        logic [31:0] lo;
    } md_res_t;

    function automatic logic op_is_div(input op_e op);
        return (op == op_div) || (op == op_divu);
    endfunction

    function automatic logic op_is_signed(input op_e op);
        return (op == op_mult) || (op == op_div);
    endfunction

endpackage

`default_nettype wire

// File: src/muldiv_route_pkg.sv
`default_nettype none

package muldiv_route_pkg;

    // upper bound on the number of divider lanes.
    localparam int MAX_LANES = 8;

    // 0 is the multiplier, k+1 is divider lane k.
    typedef logic [3:0] unit_id_t;

    localparam unit_id_t UNIT_MUL = 4'd0;

    // one entry per accepted operation, in issue order.
    typedef struct packed {
        unit_id_t unit;
    } order_entry_t;

endpackage

`default_nettype wire

// File: src/muldiv_unit.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_unit #(
    parameter int NUM_LANES   = 4,
    parameter int ORDER_DEPTH = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  muldiv_op_pkg::md_req_t in_req,
    output logic                   out_valid,
    input  logic                   out_ready,
    output muldiv_op_pkg::md_res_t out_res
);

    import muldiv_op_pkg::*;
    import muldiv_route_pkg::*;

    md_req_t              unit_req;
    logic                 mul_valid;
    logic                 mul_ready;
    logic                 mul_res_valid;
    md_res_t              mul_res;
    logic                 mul_res_ready;
    logic [NUM_LANES-1:0] lane_valid;
    logic [NUM_LANES-1:0] lane_idle;
    logic [NUM_LANES-1:0] lane_res_valid;
    logic [NUM_LANES-1:0] lane_res_ready;
    md_res_t              lane_res [NUM_LANES];
    logic                 order_push;
    order_entry_t         order_in;
    order_entry_t         order_head;
    logic                 order_pop;
    logic                 order_full;
    logic                 order_empty;
    logic                 out_push;
    md_res_t              out_data;
    logic                 out_full;
    logic                 out_empty;

    issue_dispatch #(.NUM_LANES(NUM_LANES)) u_dispatch (
        .in_valid(in_valid), .in_req(in_req), .in_ready(in_ready),
        .mul_valid(mul_valid), .mul_ready(mul_ready),
        .lane_valid(lane_valid), .lane_idle(lane_idle), .unit_req(unit_req),
        .order_push(order_push), .order_entry(order_in), .order_full(order_full),
        .flush(rst || flush)
    );

    mult_pipe u_mult (
        .clk(clk), .rst(rst), .flush(flush),
        .in_valid(mul_valid), .in_req(unit_req), .in_ready(mul_ready),
        .res_valid(mul_res_valid), .res(mul_res), .res_ready(mul_res_ready)
    );

    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        div_lane u_lane (
            .clk(clk), .rst(rst), .flush(flush),
            .start(lane_valid[k]), .req(unit_req), .idle(lane_idle[k]),
            .res_valid(lane_res_valid[k]), .res(lane_res[k]), .res_ready(lane_res_ready[k])
        );
    end

    // issue order of every operation in flight.
    sync_fifo #(.payload_t(order_entry_t), .DEPTH(ORDER_DEPTH)) u_order_fifo (
        .clk(clk), .rst(rst), .flush(flush),
        .push(order_push), .push_data(order_in), .pop(order_pop), .pop_data(order_head),
        .full(order_full), .empty(order_empty)
    );

    result_collect #(.NUM_LANES(NUM_LANES), .ORDER_DEPTH(ORDER_DEPTH)) u_collect (
        .clk(clk), .rst(rst), .order_entry(order_head), .order_empty(order_empty),
        .order_pop(order_pop), .mul_res_valid(mul_res_valid), .mul_res(mul_res),
        .mul_res_ready(mul_res_ready), .lane_res_valid(lane_res_valid), .lane_res(lane_res),
        .lane_res_ready(lane_res_ready), .out_push(out_push), .out_data(out_data),
        .out_full(out_full)
    );

    sync_fifo #(.payload_t(md_res_t), .DEPTH(2)) u_out_fifo (
        .clk(clk), .rst(rst), .flush(flush),
        .push(out_push), .push_data(out_data), .pop(out_valid && out_ready), .pop_data(out_res),
        .full(out_full), .empty(out_empty)
    );

    assign out_valid = !out_empty;

    a_lane_count: assert property (@(posedge clk)
        (NUM_LANES >= 1) && (NUM_LANES <= MAX_LANES));

endmodule

`default_nettype wire

// File: src/mult_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module mult_pipe (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    in_valid,
    input  muldiv_op_pkg::md_req_t  in_req,
    output logic                    in_ready,
    output logic                    res_valid,
    output muldiv_op_pkg::md_res_t  res,
    input  logic                    res_ready
);

    import muldiv_op_pkg::*;

    logic               advance;
    logic               ext;
    logic               s1_valid;
    logic               s2_valid;
    logic               s3_valid;
    logic signed [32:0] s1_a;
    logic signed [32:0] s1_b;
    logic        [31:0] s2_ll;
    logic signed [33:0] s2_lh;
    logic signed [33:0] s2_hl;
    logic signed [33:0] s2_hh;
    logic        [65:0] sum;
    md_res_t            s3_res;

    // the whole pipe moves only when the last stage can drain.
    assign advance  = !s3_valid || res_ready;
    assign in_ready = advance;
    assign ext      = op_is_signed(in_req.op);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= in_valid;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
        end
    end

    ////////////////////////////////////////
    // datapath.
    ////////////////////////////////////////

    // high halves are 17 bits signed, low halves 16 bits unsigned.
    assign sum = (66'(s2_hh) << 32) + (66'(s2_lh) << 16) + (66'(s2_hl) << 16) + 66'(s2_ll);

    always_ff @(posedge clk) begin
        if (advance) begin
            s1_a   <= {ext & in_req.a[31], in_req.a};
            s1_b   <= {ext & in_req.b[31], in_req.b};
            s2_ll  <= s1_a[15:0] * s1_b[15:0];
            s2_lh  <= $signed(s1_a[32:16]) * $signed({1'b0, s1_b[15:0]});
            s2_hl  <= $signed({1'b0, s1_a[15:0]}) * $signed(s1_b[32:16]);
            s2_hh  <= $signed(s1_a[32:16]) * $signed(s1_b[32:16]);
            s3_res <= sum[63:0];
        end
    end

    assign res_valid = s3_valid;
    assign res       = s3_res;

endmodule

`default_nettype wire

// File: src/result_collect.sv
`timescale 1ns/1ps
`default_nettype none

module result_collect #(
    parameter int NUM_LANES   = 4,
    parameter int ORDER_DEPTH = 8
) (
    input  logic                           clk,
    input  logic                           rst,
    input  muldiv_route_pkg::order_entry_t order_entry,
    input  logic                           order_empty,
    output logic                           order_pop,
    input  logic                           mul_res_valid,
    input  muldiv_op_pkg::md_res_t         mul_res,
    output logic                           mul_res_ready,
    input  logic [NUM_LANES-1:0]           lane_res_valid,
    input  muldiv_op_pkg::md_res_t         lane_res [NUM_LANES],
    output logic [NUM_LANES-1:0]           lane_res_ready,
    output logic                           out_push,
    output muldiv_op_pkg::md_res_t         out_data,
    input  logic                           out_full
);

    import muldiv_op_pkg::*;
    import muldiv_route_pkg::*;

    localparam int NU         = NUM_LANES + 1;
    localparam int WAIT_LIMIT = ORDER_DEPTH + 33;
    localparam int WAIT_W     = $clog2(WAIT_LIMIT + 2);

    logic [NU-1:0] unit_valid;
    logic [NU-1:0] unit_ready;
    md_res_t       unit_res [NU];
    unit_id_t      head_id;
    logic          sel_valid;
    md_res_t       sel_res;
    logic          take;

    assign unit_valid = {lane_res_valid, mul_res_valid};
    assign head_id    = order_entry.unit;

    // mux the result of the unit at the order head.
    always_comb begin
        unit_res[0] = mul_res;
        for (int k = 0; k < NUM_LANES; k++) begin
            unit_res[k+1] = lane_res[k];
        end
        sel_valid = 1'b0;
        sel_res   = '0;
        for (int u = 0; u < NU; u++) begin
            if (!order_empty && head_id == unit_id_t'(u)) begin
                sel_valid = unit_valid[u];
                sel_res   = unit_res[u];
            end
        end
    end

    assign take       = sel_valid && !out_full;
    assign out_push   = take;
    assign out_data   = sel_res;
    assign order_pop  = take;
    assign unit_ready = take ? (NU'(1) << head_id) : '0;

    assign mul_res_ready  = unit_ready[0];
    assign lane_res_ready = unit_ready[NU-1:1];

    ////////////////////////////////////////
    // bound on how long a finished unit waits behind the head.
    ////////////////////////////////////////

    for (genvar u = 0; u < NU; u++) begin : g_wait
        logic              at_head;
        logic [WAIT_W-1:0] wait_cnt;

        assign at_head = !order_empty && (head_id == unit_id_t'(u));

        // only cycles without output back-pressure count.
        always_ff @(posedge clk) begin
            if (rst || !unit_valid[u] || at_head) begin
                wait_cnt <= '0;
            end else if (!out_full && wait_cnt != WAIT_W'(WAIT_LIMIT + 1)) begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end

        a_wait_bound: assert property (@(posedge clk) disable iff (rst)
            wait_cnt <= WAIT_W'(WAIT_LIMIT));
    end

endmodule

`default_nettype wire

// File: src/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 2
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     full,
    output logic     empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;

    // pointer wrap for depths that are not a power of two.
    function automatic logic [AW-1:0] bump(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full     = (count == CW'(DEPTH));
    assign empty    = (count == '0);
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= bump(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= bump(rd_ptr);
            end
            count <= count + CW'(push) - CW'(pop);
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst || flush) push |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (rst || flush) pop |-> !empty);

endmodule

`default_nettype wire

// File: test/muldiv_vectors.svh
`ifndef MULDIV_VECTORS_SVH
`define MULDIV_VECTORS_SVH

// columns are op, a, b, expected hi, expected lo, kind.
// multiply gives hi/lo product halves, divide gives remainder/quotient.

// normal entry, checked on return.
localparam logic [1:0] K_NORM = 2'd0;
// run of divides that must each be accepted on the first cycle offered.
localparam logic [1:0] K_B2B  = 2'd1;
// run that is flushed while in flight and never returns.
localparam logic [1:0] K_DROP = 2'd2;

typedef struct packed {
    op_e         op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] hi;
    logic [31:0] lo;
    logic [1:0]  kind;
} vec_t;

localparam int NUM_VEC = 36;

localparam vec_t VECTORS [NUM_VEC] = '{
    '{op_mult,  32'h0000_0003, 32'h0000_0005, 32'h0000_0000, 32'h0000_000f, K_NORM},
    '{op_mult,  32'hffff_fffe, 32'h0000_0007, 32'hffff_ffff, 32'hffff_fff2, K_NORM},
    '{op_mult,  32'h8000_0000, 32'h8000_0000, 32'h4000_0000, 32'h0000_0000, K_NORM},
    '{op_mult,  32'hffff_ffff, 32'hffff_ffff, 32'h0000_0000, 32'h0000_0001, K_NORM},
    '{op_multu, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_fffe, 32'h0000_0001, K_NORM},
    '{op_multu, 32'h8000_0000, 32'h0000_0002, 32'h0000_0001, 32'h0000_0000, K_NORM},
    '{op_mult,  32'h8000_0000, 32'h7fff_ffff, 32'hc000_0000, 32'h8000_0000, K_NORM},
    '{op_mult,  32'h7fff_ffff, 32'h7fff_ffff, 32'h3fff_ffff, 32'h0000_0001, K_NORM},
    '{op_multu, 32'hffff_ffff, 32'h0000_0002, 32'h0000_0001, 32'hffff_fffe, K_NORM},
    '{op_mult,  32'hffff_ff9c, 32'hffff_ff9c, 32'h0000_0000, 32'h0000_2710, K_NORM},
    '{op_divu,  32'h0000_0064, 32'h0000_0007, 32'h0000_0002, 32'h0000_000e, K_NORM},
    '{op_mult,  32'h0001_2345, 32'h0001_0000, 32'h0000_0001, 32'h2345_0000, K_NORM},
    '{op_div,   32'hffff_fff9, 32'h0000_0002, 32'hffff_ffff, 32'hffff_fffd, K_NORM},
    '{op_div,   32'h0000_0007, 32'hffff_fffe, 32'h0000_0001, 32'hffff_fffd, K_NORM},
    '{op_multu, 32'h0000_0003, 32'hffff_ffff, 32'h0000_0002, 32'hffff_fffd, K_NORM},
    '{op_div,   32'hffff_fff9, 32'hffff_fffe, 32'hffff_ffff, 32'h0000_0003, K_NORM},
    '{op_divu,  32'hffff_ffff, 32'h0000_0001, 32'h0000_0000, 32'hffff_ffff, K_NORM},
    '{op_divu,  32'h8000_0000, 32'h0000_0003, 32'h0000_0002, 32'h2aaa_aaaa, K_NORM},
    '{op_div,   32'h8000_0000, 32'h0000_0003, 32'hffff_fffe, 32'hd555_5556, K_NORM},
    '{op_mult,  32'hffff_ffff, 32'h0000_0002, 32'hffff_ffff, 32'hffff_fffe, K_NORM},
    '{op_divu,  32'hffff_ffff, 32'h0000_0010, 32'h0000_000f, 32'h0fff_ffff, K_NORM},
    '{op_divu,  32'h0000_0005, 32'h0000_000a, 32'h0000_0005, 32'h0000_0000, K_NORM},
    '{op_div,   32'h0000_1234, 32'h0000_0000, 32'h0000_1234, 32'hffff_ffff, K_NORM},
    '{op_div,   32'hffff_ff00, 32'h0000_0000, 32'hffff_ff00, 32'hffff_ffff, K_NORM},
    '{op_divu,  32'h8000_0000, 32'h0000_0000, 32'h8000_0000, 32'hffff_ffff, K_NORM},
    '{op_divu,  32'h0000_03e8, 32'h0000_000a, 32'h0000_0000, 32'h0000_0064, K_B2B},
    '{op_divu,  32'hdead_beef, 32'h0001_0000, 32'h0000_beef, 32'h0000_dead, K_B2B},
    '{op_div,   32'hffff_fc18, 32'h0000_0007, 32'hffff_fffa, 32'hffff_ff72, K_B2B},
    '{op_divu,  32'h0000_000c, 32'h0000_0005, 32'h0000_0002, 32'h0000_0002, K_B2B},
    '{op_divu,  32'h0000_0032, 32'h0000_0003, 32'h0000_0002, 32'h0000_0010, K_DROP},
    '{op_div,   32'h0000_0009, 32'h0000_0002, 32'h0000_0001, 32'h0000_0004, K_DROP},
    '{op_mult,  32'h0000_0006, 32'h0000_0007, 32'h0000_0000, 32'h0000_002a, K_DROP},
    '{op_mult,  32'h0000_0003, 32'h0000_0005, 32'h0000_0000, 32'h0000_000f, K_NORM},
    '{op_div,   32'hffff_fff9, 32'h0000_0002, 32'hffff_ffff, 32'hffff_fffd, K_NORM},
    '{op_multu, 32'h8000_0000, 32'h0000_0002, 32'h0000_0001, 32'h0000_0000, K_NORM},
    '{op_divu,  32'h0000_0064, 32'h0000_0007, 32'h0000_0002, 32'h0000_000e, K_NORM}
};

`endif

// File: test/muldiv_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_unit_tb;

    import muldiv_op_pkg::*;

    `include "muldiv_vectors.svh"

    localparam int NUM_LANES      = 4;
    localparam int ORDER_DEPTH    = 8;
    localparam int TIMEOUT_CYCLES = NUM_VEC * 40 + 200;
    // idle cycles at the end to catch a late duplicate.
    localparam int SETTLE_CYCLES  = 20;

    logic    clk;
    logic    rst;
    logic    flush;
    logic    in_valid;
    logic    in_ready;
    md_req_t in_req;
    logic    out_valid;
    logic    out_ready;
    md_res_t out_res;

    integer  seed;
    int      errors = 0;
    int      checks = 0;
    int      cycles = 0;
    int      issued = 0;
    int      received = 0;
    int      next_idx = 0;
    int      total_expected = 0;

    muldiv_unit #(
        .NUM_LANES(NUM_LANES),
        .ORDER_DEPTH(ORDER_DEPTH)
    ) DUT (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .in_req(in_req),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_res(out_res)
    );

    ////////////////////////////////////////
    // helpers.
    ////////////////////////////////////////

    task automatic end_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    task automatic check_field(input string name, input int idx,
                               input logic [31:0] expected, input logic [31:0] actual);
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            $display("error: t=%0t %s (entry %0d) expected %h got %h",
                     $time, name, idx, expected, actual);
        end
    endtask

    function automatic int count_kept();
        int n;
        n = 0;
        for (int i = 0; i < NUM_VEC; i++) begin
            if (VECTORS[i].kind != K_DROP) begin
                n = n + 1;
            end
        end
        return n;
    endfunction

    // returns just after the edge on which the last outstanding result left.
    task automatic wait_drain();
        while (received != issued) begin
            @(posedge clk);
        end
        #1;
    endtask

    // offer one entry and hold it until the DUT takes it.
    task automatic issue_entry(input int idx);
        logic accepted;
        logic first_try;
        accepted    = 1'b0;
        first_try   = 1'b1;
        in_valid    = 1'b1;
        in_req.op   = VECTORS[idx].op;
        in_req.a    = VECTORS[idx].a;
        in_req.b    = VECTORS[idx].b;
        while (!accepted) begin
            @(negedge clk);
            accepted = in_ready;
            if (first_try && VECTORS[idx].kind == K_B2B) begin
                checks = checks + 1;
                if (!accepted) begin
                    errors = errors + 1;
                    $display("in_ready fell while back-to-back divide %0d was offered", idx);
                end
            end
            first_try = 1'b0;
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
        if (VECTORS[idx].kind != K_DROP) begin
            issued = issued + 1;
        end
    endtask

    task automatic pulse_flush();
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
    endtask

    ////////////////////////////////////////
    // clock, timeout, output back-pressure.
    ////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        errors = errors + 1;
        $display("timeout after %0d cycles with %0d of %0d results received",
                 cycles, received, total_expected);
        end_run();
    end

    initial begin
        seed      = 32'haaf9_c177;
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            out_ready = ($random(seed) & 3) != 0;
        end
    end

    // monitor. results must come back in table order, dropped entries skipped.
    initial begin
        forever begin
            @(negedge clk);
            if (!rst && out_valid && out_ready) begin
                while (next_idx < NUM_VEC && VECTORS[next_idx].kind == K_DROP) begin
                    next_idx = next_idx + 1;
                end
                if (next_idx >= NUM_VEC) begin
                    errors = errors + 1;
                    $display("unexpected result %h after every entry was returned", out_res);
                end else begin
                    check_field("out_res.hi", next_idx, VECTORS[next_idx].hi, out_res.hi);
                    check_field("out_res.lo", next_idx, VECTORS[next_idx].lo, out_res.lo);
                    next_idx = next_idx + 1;
                    received = received + 1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // driver.
    ////////////////////////////////////////

    initial begin
        logic [1:0] prev_kind;
        logic       last_drop;
        rst            = 1'b1;
        flush          = 1'b0;
        in_valid       = 1'b0;
        in_req         = '0;
        prev_kind      = K_NORM;
        total_expected = count_kept();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < NUM_VEC; i++) begin
            // special runs start from an empty unit.
            if (VECTORS[i].kind != K_NORM && VECTORS[i].kind != prev_kind) begin
                wait_drain();
            end
            issue_entry(i);
            if (VECTORS[i].kind == K_DROP) begin
                last_drop = (i == NUM_VEC - 1) || (VECTORS[i + 1].kind != K_DROP);
                if (last_drop) begin
                    pulse_flush();
                end
            end
            prev_kind = VECTORS[i].kind;
        end

        while (received != total_expected) begin
            @(posedge clk);
        end
        repeat (SETTLE_CYCLES) @(posedge clk);
        end_run();
    end

endmodule

`default_nettype wire
